// ==== tb.f ====
+incdir+tb
hdl/cnn_pkg.sv
hdl/line_window.sv
hdl/conv3x3.sv
hdl/maxpool2x2.sv
hdl/channel_sum.sv
hdl/cnn_model.sv
tb/tb_cnn_model.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_cnn_model -f tb.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
exit 0

// ==== tb/cnn_ref_model.svh ====
// reference model of conv, ReLU, 2x2 max pool and channel sum that the testbench includes
`ifndef CNN_REF_MODEL_SVH
`define CNN_REF_MODEL_SVH

// one activation at conv output position (r, c)
function automatic value_t conv_activation_model(input value_t img [IMG_HEIGHT][IMG_WIDTH],
                                                 input int ch, input int r, input int c);
    longint acc;
    acc = 0;
    for (int kr = 0; kr < KERNEL_SIZE; kr++) begin
        for (int kc = 0; kc < KERNEL_SIZE; kc++) begin
            acc = acc + longint'(img[r+kr][c+kc]) * longint'(CONV_WEIGHTS[ch][kr][kc]);
        end
    end
    acc = (acc >>> FRAC_BITS) + longint'(CONV_BIAS[ch]);
    if (acc < 0) begin
        return '0;
    end
    if (acc > longint'(VALUE_MAX)) begin
        return VALUE_MAX;
    end
    return value_t'(acc);
endfunction

// sum of the pooled map for one channel
function automatic sum_t pooled_sum_model(input value_t img [IMG_HEIGHT][IMG_WIDTH],
                                          input int ch);
    sum_t   total;
    value_t best;
    value_t a;
    total = '0;
    for (int pr = 0; pr < POOL_HEIGHT; pr++) begin
        for (int pc = 0; pc < POOL_WIDTH; pc++) begin
            best = conv_activation_model(img, ch, POOL_SIZE * pr, POOL_SIZE * pc);
            for (int dr = 0; dr < POOL_SIZE; dr++) begin
                for (int dc = 0; dc < POOL_SIZE; dc++) begin
                    a = conv_activation_model(img, ch, POOL_SIZE * pr + dr, POOL_SIZE * pc + dc);
                    if (a > best) begin
                        best = a;
                    end
                end
            end
            total = total + sum_t'(best);
        end
    end
    return total;
endfunction

`endif

// ==== tb/tb_cnn_model.sv ====
// testbench for cnn_model that streams LFSR images with random stalls and checks sums against a model
`timescale 1ns/1ps
`default_nettype none

module tb_cnn_model import cnn_pkg::*; ();

    localparam int MODE_WIDE     = 0;
    localparam int MODE_SMALL    = 1;
    localparam int MODE_NEAR_MAX = 2;
    localparam int TIMEOUT       = 2000;

    logic   clk = 1'b0;
    logic   i_rst;
    value_t i_data;
    logic   i_valid;
    logic   i_last;
    logic   o_ready;
    sum_t   o_data [CONV_CHANNELS];
    logic   o_valid;
    logic   o_last;
    logic   i_ready;

    logic [16:0] lfsr_state = 17'd71395;

    // pixels still to send and expected sums in image order
    value_t pix_q [$];
    logic   last_q [$];
    sum_t   exp_q [$];
    int     images_in = 0;
    int     images_out = 0;
    int     ready_run = 0;

    always #5 clk = ~clk;

    cnn_model dut_i (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_data  (i_data),
        .i_valid (i_valid),
        .i_last  (i_last),
        .o_ready (o_ready),
        .o_data  (o_data),
        .o_valid (o_valid),
        .o_last  (o_last),
        .i_ready (i_ready)
    );

    // taps 17 and 14
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[16] ^ lfsr_state[13];
        lfsr_state = {lfsr_state[15:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_sum(input int ch, input sum_t got, input sum_t exp);
        if (got !== exp) begin
            report_error($sformatf("mismatch o_data[%0d]: got %h expected %h", ch, got, exp));
        end
    endtask

    task automatic check_last(input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("mismatch o_last: got %h expected %h", got, exp));
        end
    endtask

    task automatic queue_image(input int mode);
        value_t img [IMG_HEIGHT][IMG_WIDTH];
        for (int r = 0; r < IMG_HEIGHT; r++) begin
            for (int c = 0; c < IMG_WIDTH; c++) begin
                case (mode)
                    MODE_SMALL:    img[r][c] = value_t'(rand_bits(8));
                    MODE_NEAR_MAX: img[r][c] = VALUE_MAX - value_t'(rand_bits(8));
                    default:       img[r][c] = value_t'(rand_bits(10));
                endcase
                pix_q.push_back(img[r][c]);
                last_q.push_back(r == IMG_HEIGHT - 1 && c == IMG_WIDTH - 1);
            end
        end
        for (int ch = 0; ch < CONV_CHANNELS; ch++) begin
            exp_q.push_back(pooled_sum_model(img, ch));
        end
    endtask

    // a pixel not yet taken stays on the bus
    task automatic drive_inputs(input logic gaps, input logic hold);
        if (!hold) begin
            if (pix_q.size() > 0 && !(gaps && rand_bits(2) == 0)) begin
                i_valid = 1'b1;
                i_data  = pix_q[0];
                i_last  = last_q[0];
            end else begin
                i_valid = 1'b0;
                i_data  = '0;
                i_last  = 1'b0;
            end
        end
        // sink ready moves in runs long enough to back up every stage
        if (!gaps) begin
            i_ready = 1'b1;
        end else if (ready_run > 0) begin
            ready_run--;
        end else begin
            i_ready   = rand_bits(1) != 0;
            ready_run = int'(rand_bits(7));
        end
    endtask

    task automatic run_stream(input logic gaps);
        int   idle;
        logic take;
        logic give;
        idle = 0;
        drive_inputs(gaps, 1'b0);
        while (exp_q.size() > 0) begin
            @(negedge clk);
            take = i_valid && o_ready;
            give = o_valid && i_ready;
            if (o_valid && images_in == images_out) begin
                report_error("result beat appeared with no completed image pending");
            end
            if (give) begin
                for (int ch = 0; ch < CONV_CHANNELS; ch++) begin
                    check_sum(ch, o_data[ch], exp_q.pop_front());
                end
                check_last(o_last, 1'b1);
                images_out++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    report_error("timeout while waiting for a result beat");
                end
            end
            if (take) begin
                if (last_q[0]) begin
                    images_in++;
                end
                void'(pix_q.pop_front());
                void'(last_q.pop_front());
            end
            @(posedge clk);
            #1;
            drive_inputs(gaps, i_valid && !take);
        end
    endtask

    initial begin
        i_rst   = 1'b1;
        i_data  = '0;
        i_valid = 1'b0;
        i_last  = 1'b0;
        i_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        i_rst = 1'b0;

        repeat (4) queue_image(MODE_WIDE);
        run_stream(1'b0);
        // bias pushes part of these below zero
        repeat (4) queue_image(MODE_SMALL);
        run_stream(1'b0);
        repeat (6) queue_image(MODE_WIDE);
        run_stream(1'b1);
        repeat (3) queue_image(MODE_NEAR_MAX);
        run_stream(1'b1);

        i_ready = 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (o_valid) begin
                report_error("extra result beat after the last image");
            end
        end
        $display("*** PASSED ***");
        $finish;
    end

`include "cnn_ref_model.svh"

endmodule

`default_nettype wire

// ==== hdl/cnn_model.sv ====
// top level of the classifier front end, chains conv, max pool and channel sum over streams
`timescale 1ns/1ps
`default_nettype none

module cnn_model import cnn_pkg::*; (
    input  wire          clk,
    input  wire          i_rst,
    input  wire value_t  i_data,
    input  wire          i_valid,
    input  wire          i_last,
    output logic         o_ready,
    output sum_t         o_data [CONV_CHANNELS],
    output logic         o_valid,
    output logic         o_last,
    input  wire          i_ready
);

    // conv to pool
    value_t conv_data [CONV_CHANNELS];
    logic   conv_valid;
    logic   conv_last;
    logic   pool_ready;

    // pool to sum
    value_t pool_data [CONV_CHANNELS];
    logic   pool_valid;
    logic   pool_last;
    logic   sum_ready;

    conv3x3 conv_i (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_data  (i_data),
        .i_valid (i_valid),
        .i_last  (i_last),
        .o_ready (o_ready),
        .o_data  (conv_data),
        .o_valid (conv_valid),
        .o_last  (conv_last),
        .i_ready (pool_ready)
    );

    maxpool2x2 pool_i (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_data  (conv_data),
        .i_valid (conv_valid),
        .i_last  (conv_last),
        .o_ready (pool_ready),
        .o_data  (pool_data),
        .o_valid (pool_valid),
        .o_last  (pool_last),
        .i_ready (sum_ready)
    );

    channel_sum sum_i (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_data  (pool_data),
        .i_valid (pool_valid),
        .i_last  (pool_last),
        .o_ready (sum_ready),
        .o_data  (o_data),
        .o_valid (o_valid),
        .o_last  (o_last),
        .i_ready (i_ready)
    );

endmodule

`default_nettype wire

// ==== hdl/channel_sum.sv ====
// per-channel sum of the pooled map that emits one result beat at the end of each image
`timescale 1ns/1ps
`default_nettype none

module channel_sum import cnn_pkg::*; (
    input  wire          clk,
    input  wire          i_rst,
    input  wire value_t  i_data [CONV_CHANNELS],
    input  wire          i_valid,
    input  wire          i_last,
    output logic         o_ready,
    output sum_t         o_data [CONV_CHANNELS],
    output logic         o_valid,
    output logic         o_last,
    input  wire          i_ready
);

    sum_t acc   [CONV_CHANNELS];
    sum_t total [CONV_CHANNELS];
    logic accept;

    assign o_ready = !o_valid || i_ready;
    assign accept  = i_valid && o_ready;
    // a result always closes an image
    assign o_last  = o_valid;

    always_comb begin
        for (int ch = 0; ch < CONV_CHANNELS; ch++) begin
            total[ch] = acc[ch] + sum_t'(i_data[ch]);
        end
    end

    always_ff @(posedge clk) begin
        if (accept && i_last) begin
            o_data <= total;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            acc     <= '{default: '0};
            o_valid <= 1'b0;
        end else begin
            if (accept) begin
                for (int ch = 0; ch < CONV_CHANNELS; ch++) begin
                    acc[ch] <= i_last ? '0 : total[ch];
                end
            end
            if (accept && i_last) begin
                o_valid <= 1'b1;
            end else if (i_ready) begin
                o_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/maxpool2x2.sv ====
// 2x2 max pooling over the convolution stream, one output beat per complete block
`timescale 1ns/1ps
`default_nettype none

module maxpool2x2 import cnn_pkg::*; (
    input  wire          clk,
    input  wire          i_rst,
    input  wire value_t  i_data [CONV_CHANNELS],
    input  wire          i_valid,
    input  wire          i_last,
    output logic         o_ready,
    output value_t       o_data [CONV_CHANNELS],
    output logic         o_valid,
    output logic         o_last,
    input  wire          i_ready
);

    localparam int COL_BITS = $clog2(CONV_WIDTH);
    localparam int ROW_BITS = $clog2(CONV_HEIGHT);
    localparam logic [COL_BITS-1:0] COL_LAST = COL_BITS'(CONV_WIDTH - 1);

    logic [COL_BITS-1:0] col_cnt;
    logic [ROW_BITS-1:0] row_cnt;
    logic [COL_BITS-2:0] pool_col;
    logic                accept;
    logic                block_done;

    value_t pair_left [CONV_CHANNELS];
    value_t pair_max  [CONV_CHANNELS];
    value_t row_buf   [CONV_CHANNELS][POOL_WIDTH];

    function automatic value_t max_v(input value_t a, input value_t b);
        return (a > b) ? a : b;
    endfunction

    assign o_ready    = !o_valid || i_ready;
    assign accept     = i_valid && o_ready;
    assign pool_col   = col_cnt[COL_BITS-1:1];
    // lower-right element of a block
    assign block_done = accept && col_cnt[0] && row_cnt[0];

    always_comb begin
        for (int ch = 0; ch < CONV_CHANNELS; ch++) begin
            pair_max[ch] = max_v(pair_left[ch], i_data[ch]);
        end
    end

    always_ff @(posedge clk) begin
        for (int ch = 0; ch < CONV_CHANNELS; ch++) begin
            if (accept && !col_cnt[0]) begin
                pair_left[ch] <= i_data[ch];
            end
            if (accept && col_cnt[0] && !row_cnt[0]) begin
                row_buf[ch][pool_col] <= pair_max[ch];
            end
            if (block_done) begin
                o_data[ch] <= max_v(row_buf[ch][pool_col], pair_max[ch]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
            o_valid <= 1'b0;
            o_last  <= 1'b0;
        end else begin
            if (accept) begin
                if (i_last) begin
                    col_cnt <= '0;
                    row_cnt <= '0;
                end else if (col_cnt == COL_LAST) begin
                    col_cnt <= '0;
                    row_cnt <= row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
            if (block_done) begin
                o_valid <= 1'b1;
                o_last  <= i_last;
            end else if (i_ready) begin
                o_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/conv3x3.sv ====
// 3x3 convolution stage with per-channel MAC, bias, ReLU and saturation, one registered output beat
`timescale 1ns/1ps
`default_nettype none

module conv3x3 import cnn_pkg::*; (
    input  wire          clk,
    input  wire          i_rst,
    input  wire value_t  i_data,
    input  wire          i_valid,
    input  wire          i_last,
    output logic         o_ready,
    output value_t       o_data [CONV_CHANNELS],
    output logic         o_valid,
    output logic         o_last,
    input  wire          i_ready
);

    value_t window [KERNEL_SIZE][KERNEL_SIZE];
    logic   window_valid;
    logic   window_last;
    logic   accept;

    acc_t   mac    [CONV_CHANNELS];
    acc_t   biased [CONV_CHANNELS];
    value_t result [CONV_CHANNELS];

    // free to take a pixel when the output slot is empty or draining
    assign o_ready = !o_valid || i_ready;
    assign accept  = i_valid && o_ready;

    line_window line_window_i (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_shift        (accept),
        .i_pixel        (i_data),
        .i_last         (i_last),
        .o_window       (window),
        .o_window_valid (window_valid),
        .o_window_last  (window_last)
    );

    always_comb begin
        for (int ch = 0; ch < CONV_CHANNELS; ch++) begin
            mac[ch] = '0;
            for (int r = 0; r < KERNEL_SIZE; r++) begin
                for (int c = 0; c < KERNEL_SIZE; c++) begin
                    mac[ch] = mac[ch] + acc_t'(window[r][c]) * acc_t'(CONV_WEIGHTS[ch][r][c]);
                end
            end
            biased[ch] = (mac[ch] >>> FRAC_BITS) + acc_t'(CONV_BIAS[ch]);
            // relu, then clamp to the activation range
            if (biased[ch] < 0) begin
                result[ch] = '0;
            end else if (biased[ch] > acc_t'(VALUE_MAX)) begin
                result[ch] = VALUE_MAX;
            end else begin
                result[ch] = value_t'(biased[ch]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (window_valid) begin
            o_data <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
            o_last  <= 1'b0;
        end else if (window_valid) begin
            o_valid <= 1'b1;
            o_last  <= window_last;
        end else if (i_ready) begin
            o_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/line_window.sv ====
// row buffers and counters that turn a pixel stream into a sliding 3x3 window for the conv stage
`timescale 1ns/1ps
`default_nettype none

module line_window import cnn_pkg::*; (
    input  wire          clk,
    input  wire          i_rst,
    input  wire          i_shift,
    input  wire value_t  i_pixel,
    input  wire          i_last,
    output value_t       o_window [KERNEL_SIZE][KERNEL_SIZE],
    output logic         o_window_valid,
    output logic         o_window_last
);

    localparam int COL_BITS = $clog2(IMG_WIDTH);
    localparam int ROW_BITS = $clog2(IMG_HEIGHT);
    localparam logic [COL_BITS-1:0] COL_LAST = COL_BITS'(IMG_WIDTH - 1);

    logic [COL_BITS-1:0] col_cnt;
    logic [ROW_BITS-1:0] row_cnt;

    // two rows above the incoming pixel
    value_t line_top [IMG_WIDTH];
    value_t line_mid [IMG_WIDTH];

    // left columns of the window, the right one comes straight from the buffers
    value_t win [KERNEL_SIZE][KERNEL_SIZE-1];
    value_t new_col [KERNEL_SIZE];

    assign new_col[0] = line_top[col_cnt];
    assign new_col[1] = line_mid[col_cnt];
    assign new_col[2] = i_pixel;

    always_comb begin
        for (int r = 0; r < KERNEL_SIZE; r++) begin
            for (int c = 0; c < KERNEL_SIZE - 1; c++) begin
                o_window[r][c] = win[r][c];
            end
            o_window[r][KERNEL_SIZE-1] = new_col[r];
        end
    end

    assign o_window_valid = i_shift && (col_cnt >= COL_BITS'(KERNEL_SIZE - 1))
                            && (row_cnt >= ROW_BITS'(KERNEL_SIZE - 1));
    assign o_window_last  = o_window_valid && i_last;

    always_ff @(posedge clk) begin
        if (i_shift) begin
            line_top[col_cnt] <= line_mid[col_cnt];
            line_mid[col_cnt] <= i_pixel;
            for (int r = 0; r < KERNEL_SIZE; r++) begin
                for (int c = 0; c < KERNEL_SIZE - 2; c++) begin
                    win[r][c] <= win[r][c+1];
                end
                win[r][KERNEL_SIZE-2] <= new_col[r];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_shift) begin
            if (i_last) begin
                col_cnt <= '0;
                row_cnt <= '0;
            end else if (col_cnt == COL_LAST) begin
                col_cnt <= '0;
                row_cnt <= row_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cnn_pkg.sv ====
// shared sizes, fixed-point types and layer constants, imported by every RTL module and the testbench
`default_nettype none

package cnn_pkg;

    localparam int IMG_WIDTH     = 8;
    localparam int IMG_HEIGHT    = 8;
    localparam int KERNEL_SIZE   = 3;
    localparam int CONV_WIDTH    = IMG_WIDTH - 2;
    localparam int CONV_HEIGHT   = IMG_HEIGHT - 2;
    localparam int POOL_SIZE     = 2;
    localparam int POOL_WIDTH    = CONV_WIDTH / POOL_SIZE;
    localparam int POOL_HEIGHT   = CONV_HEIGHT / POOL_SIZE;
    localparam int CONV_CHANNELS = 2;
    localparam int VALUE_BITS    = 18;
    localparam int FRAC_BITS     = 12;

    typedef logic signed [VALUE_BITS-1:0]   value_t;
    typedef logic signed [17:0]             weight_t;
    typedef logic signed [39:0]             acc_t;
    // nine pooled maxima per image need four extra bits
    typedef logic signed [VALUE_BITS+3:0]   sum_t;

    localparam value_t VALUE_MAX = {1'b0, {(VALUE_BITS-1){1'b1}}};

    // first-layer kernels 0 and 2 of the trained network
    localparam weight_t CONV_WEIGHTS [CONV_CHANNELS][KERNEL_SIZE][KERNEL_SIZE] = '{
        '{
            '{-18'sd10174, -18'sd104150, -18'sd91946},
            '{ 18'sd48411, -18'sd40553,  -18'sd15014},
            '{ 18'sd44825,  18'sd112022,  18'sd81093}
        },
        '{
            '{ 18'sd55276,  18'sd45645,   18'sd40350},
            '{-18'sd63657,  18'sd40389,   18'sd455},
            '{ 18'sd46677,  18'sd65183,   18'sd111589}
        }
    };

    // added after the product sum is scaled back
    localparam weight_t CONV_BIAS [CONV_CHANNELS] = '{-18'sd5046, -18'sd1722};

endpackage

`default_nettype wire
